/* cpu_pkg.sv */
package cpu_pkg;

	// ##################################################
	// Major opcodes, bits 30:25 of the instruction word
	// ##################################################
	localparam logic [5:0] TY_BASE = 6'b100000;
	localparam logic [5:0] ADDI    = 6'b101000;
	localparam logic [5:0] ORI     = 6'b101100;
	localparam logic [5:0] XORI    = 6'b101011;
	localparam logic [5:0] LWI     = 6'b000010;
	localparam logic [5:0] SWI     = 6'b001010;
	localparam logic [5:0] TY_LS   = 6'b011100;

	// Sub-opcodes of TY_BASE, bits 4:0
	localparam logic [4:0] ADD   = 5'b00000;
	localparam logic [4:0] SUB   = 5'b00001;
	localparam logic [4:0] AND   = 5'b00010;
	localparam logic [4:0] XOR   = 5'b00011;
	localparam logic [4:0] OR    = 5'b00100;
	localparam logic [4:0] SLLI  = 5'b01000;
	localparam logic [4:0] SRLI  = 5'b01001;
	localparam logic [4:0] ROTRI = 5'b01011;

	// Sub-opcodes of TY_LS, address is ra plus rb
	localparam logic [4:0] LS_LW = 5'b00010;
	localparam logic [4:0] LS_SW = 5'b01010;

	// ##################################################
	// Instruction formats
	// ##################################################
	typedef struct packed {
		logic       top;    // Must be zero for a 32-bit instruction
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;     // Also the shift amount of SRLI, SLLI and ROTRI
		logic [4:0] unused;
		logic [4:0] sub;
	} instr_r_t;

	typedef struct packed {
		logic        top;
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm15;
	} instr_i_t;

	// The opcode selects which view is meaningful
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

	// Status word bits and its Wishbone address
	localparam int ST_OVF = 0;
	localparam int ST_ILL = 1;
	localparam logic [5:0] STATUS_ADR = 6'd32;

endpackage

/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import cpu_pkg::*; (
	input  instr_t      instr,
	output logic [4:0]  ra,
	output logic [4:0]  rb,
	output logic [4:0]  rt,
	output logic [31:0] imm,
	output logic        use_imm,
	output logic        is_load,
	output logic        is_store,
	output logic        writes_rd,
	output logic        legal
);

	always_comb begin
		// Register fields sit at the same place in both formats
		ra = instr.r.ra;
		rb = instr.r.rb;
		rt = instr.r.rt;
		imm = '0;
		use_imm = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		writes_rd = 1'b0;
		legal = 1'b1;

		case (instr.r.opcode)
			TY_BASE: begin
				writes_rd = 1'b1;
				case (instr.r.sub)
					ADD, SUB, AND, OR, XOR: begin
						use_imm = 1'b0; // Both operands from registers
					end
					SRLI, SLLI, ROTRI: begin
						use_imm = 1'b1;
						imm = {27'b0, instr.r.rb};
					end
					default: legal = 1'b0;
				endcase
			end
			ADDI: begin
				use_imm = 1'b1;
				writes_rd = 1'b1;
				imm = {{17{instr.i.imm15[14]}}, instr.i.imm15};
			end
			ORI, XORI: begin
				use_imm = 1'b1;
				writes_rd = 1'b1;
				imm = {17'b0, instr.i.imm15};
			end
			LWI, SWI: begin
				use_imm = 1'b1;
				imm = {{15{instr.i.imm15[14]}}, instr.i.imm15, 2'b00}; // Word offset
				is_load = instr.i.opcode == LWI;
				is_store = instr.i.opcode == SWI;
				writes_rd = instr.i.opcode == LWI;
			end
			TY_LS: begin
				case (instr.r.sub)
					LS_LW: begin
						is_load = 1'b1;
						writes_rd = 1'b1;
					end
					LS_SW: is_store = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase

		if (instr.r.top)
			legal = 1'b0; // 16-bit forms are not supported

		if (!legal) begin
			is_load = 1'b0;
			is_store = 1'b0;
			writes_rd = 1'b0;
		end
	end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  ra_adr,
	input  logic [4:0]  rb_adr,
	input  logic [4:0]  host_adr,
	input  logic        we,
	input  logic [4:0]  wadr,
	input  logic [31:0] wdat,
	output logic [31:0] ra_dat,
	output logic [31:0] rb_dat,
	output logic [31:0] host_dat
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wadr] <= wdat;
		end
	end

	assign ra_dat = regs[ra_adr];
	assign rb_dat = regs[rb_adr];
	assign host_dat = regs[host_adr]; // Serves host reads and store data

	wadr_known: assert property (@(posedge clk) disable iff (reset)
		we |-> !$isunknown(wadr))
	else $error("Register write with unknown address");

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  logic        enable_execute,
	input  logic [31:0] alu_src1,
	input  logic [31:0] alu_src2,
	input  logic [5:0]  opcode,
	input  logic [4:0]  sub_op,
	output logic [31:0] alu_result,
	output logic        alu_overflow
);

	logic [32:0] sum;  // Overflow on top of the 32-bit result
	logic [32:0] diff;
	logic [63:0] rotate;
	logic [4:0]  shamt;
	logic        logical_op;

	// Overflow is the carry into bit 31 xor the carry out of it
	function automatic logic [32:0] add_ovf(input logic [31:0] x, input logic [31:0] y,
		input logic cin);
		logic [31:0] low;
		logic [1:0]  high;
		low = {1'b0, x[30:0]} + {1'b0, y[30:0]} + {31'b0, cin};
		high = {1'b0, x[31]} + {1'b0, y[31]} + {1'b0, low[31]};
		return {low[31] ^ high[1], high[0], low[30:0]};
	endfunction

	assign shamt = alu_src2[4:0];
	assign sum = add_ovf(alu_src1, alu_src2, 1'b0);
	assign diff = add_ovf(alu_src1, ~alu_src2, 1'b1); // Two's complement subtract
	assign rotate = {alu_src1, alu_src1} >> shamt;

	always_comb begin
		alu_result = '0;
		alu_overflow = 1'b0;
		if (enable_execute) begin
			case (opcode)
				TY_BASE: begin
					case (sub_op)
						ADD: {alu_overflow, alu_result} = sum;
						SUB: {alu_overflow, alu_result} = diff;
						AND: alu_result = alu_src1 & alu_src2;
						OR: alu_result = alu_src1 | alu_src2;
						XOR: alu_result = alu_src1 ^ alu_src2;
						SRLI: alu_result = alu_src1 >> shamt;
						SLLI: alu_result = alu_src1 << shamt;
						ROTRI: alu_result = rotate[31:0];
						default: alu_result = '0;
					endcase
				end
				ADDI, LWI, SWI, TY_LS: begin
					{alu_overflow, alu_result} = sum; // Address forms add too
				end
				ORI: alu_result = alu_src1 | alu_src2;
				XORI: alu_result = alu_src1 ^ alu_src2;
				default: alu_result = '0;
			endcase
		end
	end

	// Logical and shift codes, taken from the opcode map alone
	assign logical_op = opcode == ORI || opcode == XORI
		|| (opcode == TY_BASE && sub_op inside {AND, OR, XOR, SRLI, SLLI, ROTRI});

	always_comb begin
		if (logical_op)
			assert (!alu_overflow) else $error("Overflow raised by a logical operation");
	end

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
	parameter int RAM_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  we,
	input  logic [RAM_ADDR_W-1:0] adr,
	input  logic [31:0]           dat_w,
	output logic [31:0]           dat_r
);

	logic [31:0] mem [2**RAM_ADDR_W];

	always_ff @(posedge clk) begin
		if (we)
			mem[adr] <= dat_w;
		dat_r <= mem[adr]; // Load data one cycle after the address
	end

endmodule

/* exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl import cpu_pkg::*; #(
	parameter int RAM_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [5:0]            wb_adr,
	input  logic [31:0]           wb_dat_w,
	output logic [31:0]           wb_dat_r,
	output logic                  wb_ack,
	output instr_t                instr,
	input  logic [4:0]            ra,
	input  logic [4:0]            rb,
	input  logic [4:0]            rt,
	input  logic [31:0]           imm,
	input  logic                  use_imm,
	input  logic                  is_load,
	input  logic                  is_store,
	input  logic                  writes_rd,
	input  logic                  legal,
	output logic                  enable_execute,
	output logic [31:0]           alu_src1,
	output logic [31:0]           alu_src2,
	output logic [5:0]            opcode,
	output logic [4:0]            sub_op,
	input  logic [31:0]           alu_result,
	input  logic                  alu_overflow,
	output logic [4:0]            rf_ra_adr,
	output logic [4:0]            rf_rb_adr,
	output logic [4:0]            rf_host_adr,
	input  logic [31:0]           rf_ra_dat,
	input  logic [31:0]           rf_rb_dat,
	input  logic [31:0]           rf_host_dat,
	output logic                  rf_we,
	output logic [4:0]            rf_wadr,
	output logic [31:0]           rf_wdat,
	output logic                  mem_we,
	output logic [RAM_ADDR_W-1:0] mem_adr,
	output logic [31:0]           mem_dat_w,
	input  logic [31:0]           mem_dat_r
);

	localparam logic [1:0] S_IDLE      = 2'd0;
	localparam logic [1:0] S_EXECUTE   = 2'd1;
	localparam logic [1:0] S_LOAD_WAIT = 2'd2;

	logic [1:0] state;
	instr_t     instr_q;
	logic [1:0] status;
	logic       wb_req;

	// A request still high in the ack cycle is the one just served
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	assign instr = instr_q;
	assign opcode = instr_q.r.opcode;
	assign sub_op = instr_q.r.sub;
	assign enable_execute = state == S_EXECUTE;

	// ##################################################
	// Operand steering and write-back
	// ##################################################
	assign rf_ra_adr = ra;
	assign rf_rb_adr = rb;
	assign rf_host_adr = (state == S_IDLE) ? wb_adr[4:0] : rt; // rt is store data
	assign alu_src1 = rf_ra_dat;
	assign alu_src2 = use_imm ? imm : rf_rb_dat;

	assign mem_we = enable_execute && legal && is_store;
	assign mem_adr = alu_result[RAM_ADDR_W+1:2];
	assign mem_dat_w = rf_host_dat;

	assign rf_we = (enable_execute && legal && writes_rd && !is_load) || state == S_LOAD_WAIT;
	assign rf_wadr = rt;
	assign rf_wdat = (state == S_LOAD_WAIT) ? mem_dat_r : alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			wb_ack <= 1'b0;
			status <= '0;
		end else begin
			wb_ack <= 1'b0;
			case (state)
				S_IDLE: begin
					if (wb_req) begin
						if (wb_we && wb_adr == 6'd0)
							state <= S_EXECUTE;
						else
							wb_ack <= 1'b1; // Reads and stray writes
					end
				end
				S_EXECUTE: begin
					if (legal && is_load) begin
						state <= S_LOAD_WAIT;
					end else begin
						state <= S_IDLE;
						wb_ack <= 1'b1;
						status[ST_OVF] <= alu_overflow && writes_rd;
						status[ST_ILL] <= !legal;
					end
				end
				S_LOAD_WAIT: begin
					state <= S_IDLE;
					wb_ack <= 1'b1;
					status <= '0;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && wb_req) begin
			if (wb_we) begin
				if (wb_adr == 6'd0)
					instr_q <= wb_dat_w;
				wb_dat_r <= '0;
			end else if (wb_adr < STATUS_ADR) begin
				wb_dat_r <= rf_host_dat;
			end else if (wb_adr == STATUS_ADR) begin
				wb_dat_r <= {30'b0, status};
			end else begin
				wb_dat_r <= '0;
			end
		end
	end

	ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		$rose(wb_ack) |-> wb_cyc && wb_stb)
	else $error("Ack raised outside a bus cycle");

endmodule

/* exec_top.sv */
`timescale 1ns/1ps

module exec_top import cpu_pkg::*; #(
	parameter int RAM_ADDR_W = 8
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [5:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack
);

	instr_t                instr;
	logic [4:0]            ra;
	logic [4:0]            rb;
	logic [4:0]            rt;
	logic [31:0]           imm;
	logic                  use_imm;
	logic                  is_load;
	logic                  is_store;
	logic                  writes_rd;
	logic                  legal;
	logic                  enable_execute;
	logic [31:0]           alu_src1;
	logic [31:0]           alu_src2;
	logic [5:0]            opcode;
	logic [4:0]            sub_op;
	logic [31:0]           alu_result;
	logic                  alu_overflow;
	logic [4:0]            rf_ra_adr;
	logic [4:0]            rf_rb_adr;
	logic [4:0]            rf_host_adr;
	logic [31:0]           rf_ra_dat;
	logic [31:0]           rf_rb_dat;
	logic [31:0]           rf_host_dat;
	logic                  rf_we;
	logic [4:0]            rf_wadr;
	logic [31:0]           rf_wdat;
	logic                  mem_we;
	logic [RAM_ADDR_W-1:0] mem_adr;
	logic [31:0]           mem_dat_w;
	logic [31:0]           mem_dat_r;

	exec_ctrl #(.RAM_ADDR_W(RAM_ADDR_W)) i_ctrl (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.instr(instr), .ra(ra), .rb(rb), .rt(rt), .imm(imm), .use_imm(use_imm),
		.is_load(is_load), .is_store(is_store), .writes_rd(writes_rd), .legal(legal),
		.enable_execute(enable_execute), .alu_src1(alu_src1), .alu_src2(alu_src2),
		.opcode(opcode), .sub_op(sub_op),
		.alu_result(alu_result), .alu_overflow(alu_overflow),
		.rf_ra_adr(rf_ra_adr), .rf_rb_adr(rf_rb_adr), .rf_host_adr(rf_host_adr),
		.rf_ra_dat(rf_ra_dat), .rf_rb_dat(rf_rb_dat), .rf_host_dat(rf_host_dat),
		.rf_we(rf_we), .rf_wadr(rf_wadr), .rf_wdat(rf_wdat),
		.mem_we(mem_we), .mem_adr(mem_adr), .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r)
	);

	instr_decode i_decode (
		.instr(instr), .ra(ra), .rb(rb), .rt(rt), .imm(imm), .use_imm(use_imm),
		.is_load(is_load), .is_store(is_store), .writes_rd(writes_rd), .legal(legal)
	);

	reg_file i_regs (
		.clk(clk), .reset(reset),
		.ra_adr(rf_ra_adr), .rb_adr(rf_rb_adr), .host_adr(rf_host_adr),
		.we(rf_we), .wadr(rf_wadr), .wdat(rf_wdat),
		.ra_dat(rf_ra_dat), .rb_dat(rf_rb_dat), .host_dat(rf_host_dat)
	);

	alu i_alu (
		.enable_execute(enable_execute), .alu_src1(alu_src1), .alu_src2(alu_src2),
		.opcode(opcode), .sub_op(sub_op),
		.alu_result(alu_result), .alu_overflow(alu_overflow)
	);

	data_ram #(.RAM_ADDR_W(RAM_ADDR_W)) i_ram (
		.clk(clk), .we(mem_we), .adr(mem_adr), .dat_w(mem_dat_w), .dat_r(mem_dat_r)
	);

endmodule

/* tb_exec.sv */
`timescale 1ns/1ps

module tb_exec;

	localparam string PATTERN_FILE = "exec_patterns.txt";
	localparam int    RESET_CYCLES = 16;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [5:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	logic [7:0]  kind_q [$]; // W or R
	logic [5:0]  adr_q [$];
	logic [31:0] data_q [$]; // Write data or expected read data
	int          cycle_count = 0;
	int          cycle_limit = RESET_CYCLES + 100;

	exec_top #(.RAM_ADDR_W(8)) i_dut (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, a transfer was never acknowledged",
				cycle_count);
			$display("TEST FAILED");
			$fatal(1, "Simulation stopped by timeout");
		end
	end

	// ##################################################
	// Pattern file and bus tasks
	// ##################################################
	task automatic read_patterns();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  kind;
		logic [31:0] adr;
		logic [31:0] data;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the pattern file %s", PATTERN_FILE);
			$display("TEST FAILED");
			$fatal(1, "Missing pattern file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Comment lines and blank lines carry no transfer
				if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
					n = $sscanf(line, "%c %h %h", kind, adr, data);
					if (n != 3 || (kind != "W" && kind != "R")) begin
						$display("Malformed line in the pattern file: %s", line);
						$display("TEST FAILED");
						$fatal(1, "Bad pattern line");
					end else begin
						kind_q.push_back(kind);
						adr_q.push_back(adr[5:0]);
						data_q.push_back(data);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One Wishbone classic transfer, request held until ack is seen
	task automatic bus_transfer(input logic we, input logic [5:0] adr, input logic [31:0] dat,
		output logic [31:0] rdat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= dat;
		do begin
			@(posedge clk);
		end while (!wb_ack);
		rdat = wb_dat_r; // Registered together with ack
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
		input logic [5:0] adr);
		if (actual !== expected) begin
			$display("Error at %0t ns: read of address %0d returned %h, expected %h",
				$time, adr, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Read data mismatch");
		end
	endtask

	initial begin
		logic [31:0] rdat;
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		read_patterns();
		cycle_limit = RESET_CYCLES + 8 * kind_q.size() + 100;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		foreach (kind_q[i]) begin
			if (kind_q[i] == "W") begin
				bus_transfer(1'b1, adr_q[i], data_q[i], rdat);
			end else begin
				bus_transfer(1'b0, adr_q[i], '0, rdat);
				compare_value(rdat, data_q[i], adr_q[i]);
			end
		end

		$display("%0d transfers done in %0d cycles", kind_q.size(), cycle_count);
		$display("TEST OK");
		$finish;
	end

endmodule

/* exec_patterns.txt */
# Columns are kind, address and data, all hex. W writes the data
# R reads and expects the data. Address 20 is the status word
# Reset values
R 00 00000000
R 01 00000000
R 20 00000000
# Operands, then the eight TY_BASE sub-ops
W 00 50101234  # addi r1, r0, 0x1234
W 00 50200F0F  # addi r2, r0, 0x0f0f
W 00 40308800  # add r3, r1, r2
W 00 40408801  # sub r4, r1, r2
W 00 40508802  # and r5, r1, r2
W 00 40608804  # or r6, r1, r2
W 00 40708803  # xor r7, r1, r2
W 00 40809009  # srli r8, r1, 4
W 00 4090A008  # slli r9, r1, 8
W 00 40A0FC0B  # rotri r10, r1, 31
R 03 00002143
R 04 00000325
R 05 00000204
R 06 00001F3F
R 07 00001D3B
R 08 00000123
R 09 00123400
R 0A 00002468
# Immediate extension
W 00 50B07FF0  # addi r11, r0, -16
W 00 58C04001  # ori r12, r0, 0x4001
W 00 56D5C000  # xori r13, r11, 0x4000
R 0B FFFFFFF0
R 0C 00004001
R 0D FFFFBFF0
# Overflow flag
W 00 50E03FFF  # addi r14, r0, 0x3fff
W 00 40E74408  # slli r14, r14, 17
W 00 40F73800  # add r15, r14, r14
R 20 00000001
R 0F FFFC0000
W 00 41117C08  # slli r17, r2, 31
W 00 4128B801  # sub r18, r17, r14
R 20 00000001
R 12 00020000
W 00 41073802  # and r16, r14, r14
R 20 00000000
R 10 7FFE0000
# Memory, immediate and register offsets to the same word
W 00 51400008  # addi r20, r0, 8
W 00 51600004  # addi r22, r0, 4
W 00 143A0001  # swi r3, [r20 + 4]
W 00 053A0001  # lwi r19, [r20 + 4]
R 13 00002143
W 00 395A5802  # lw r21, [r20 + r22]
R 15 00002143
W 00 386A580A  # sw r6, [r20 + r22]
W 00 057A0001  # lwi r23, [r20 + 4]
R 17 00001F3F
# Illegal instructions
W 00 7E500000  # unknown opcode with rt r5
R 20 00000002
R 05 00000204
W 00 51800001  # addi r24, r0, 1
R 20 00000000
W 00 4060881F  # unknown sub-op with rt r6
R 20 00000002
R 06 00001F3F
W 00 D0101234  # top bit set
R 20 00000002
R 01 00001234
W 00 59900055  # ori r25, r0, 0x55
R 20 00000000
R 19 00000055
# Stray accesses
W 07 FFFFFFFF
R 07 00001D3B
R 21 00000000

/* list.f */
cpu_pkg.sv
instr_decode.sv
reg_file.sv
alu.sv
data_ram.sv
exec_ctrl.sv
exec_top.sv
tb_exec.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_exec -o Vtb_exec
./obj_dir/Vtb_exec > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
